// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= tb_bench_role
FILELIST ?= compile.f
OBJ_DIR  ?= obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
verilog/bench_pkg.sv
verilog/bench_controller.sv
verilog/access_generator.sv
verilog/stream_byte_counter.sv
verilog/bench_role.sv
dv/tb_clock_gen.sv
dv/tb_mem_responder.sv
dv/tb_bench_role.sv

// File: dv/tb_bench_role.sv
`timescale 1ns/1ns

module tb_bench_role import bench_pkg::*; ();

   localparam int TIMEOUT = 5000;                      // cycles per wait

   logic                              user_clk;
   logic                              user_aresetn;
   logic                              cmd_valid;
   logic                              cmd_ready;
   bench_cmd_t                        cmd;
   logic                              result_valid;
   logic                              result_ready;
   bench_result_t                     result;
   logic [NUM_CHANNELS-1:0]           mem_rd_cmd_valid;
   logic [NUM_CHANNELS-1:0]           mem_rd_cmd_ready;
   mem_cmd_t [NUM_CHANNELS-1:0]       mem_rd_cmd;
   logic [NUM_CHANNELS-1:0]           mem_wr_cmd_valid;
   logic [NUM_CHANNELS-1:0]           mem_wr_cmd_ready;
   mem_cmd_t [NUM_CHANNELS-1:0]       mem_wr_cmd;
   logic [NUM_CHANNELS-1:0]           mem_wr_data_valid;
   logic [NUM_CHANNELS-1:0]           mem_wr_data_ready;
   stream_word_t [NUM_CHANNELS-1:0]   mem_wr_data;
   logic [NUM_CHANNELS-1:0]           mem_rd_data_valid;
   logic [NUM_CHANNELS-1:0]           mem_rd_data_ready;
   stream_word_t [NUM_CHANNELS-1:0]   mem_rd_data;

   mem_cmd_t                exp_rd_cmd[NUM_CHANNELS][$];
   mem_cmd_t                exp_wr_cmd[NUM_CHANNELS][$];
   stream_word_t            exp_word[NUM_CHANNELS][$];
   bench_result_t           exp_res[NUM_CHANNELS];     // cycles field is a minimum
   logic [NUM_CHANNELS-1:0] exp_pending;
   logic [15:0]             rng_state;
   int                      ready_mode;                // 0 low, 1 high, 2 random
   logic                    stalled;
   bench_result_t           held_result;

   tb_clock_gen u_clk (.user_clk(user_clk), .user_aresetn(user_aresetn));

   bench_role dut0 (.*);

   for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_mem
      tb_mem_responder #(.SEED(16'd46938 + 16'(ch + 1))) u_mem (
         .user_clk      (user_clk),
         .user_aresetn  (user_aresetn),
         .rd_cmd_valid  (mem_rd_cmd_valid[ch]),
         .rd_cmd_ready  (mem_rd_cmd_ready[ch]),
         .rd_cmd        (mem_rd_cmd[ch]),
         .wr_cmd_ready  (mem_wr_cmd_ready[ch]),
         .wr_data_ready (mem_wr_data_ready[ch]),
         .rd_data_valid (mem_rd_data_valid[ch]),
         .rd_data_ready (mem_rd_data_ready[ch]),
         .rd_data       (mem_rd_data[ch])
      );
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic take_bit();
      rng_state = lfsr_step(rng_state);
      return rng_state[0];
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) report_failure($sformatf("Fail %0t %s got %b expected %b",
                                                $time, name, got, exp));
   endtask

   task automatic check_mem_cmd(input string name, input mem_cmd_t got, input mem_cmd_t exp);
      if (got !== exp) report_failure($sformatf("Fail %0t %s got %h expected %h",
                                                $time, name, got, exp));
   endtask

   task automatic check_word(input string name, input stream_word_t got, input stream_word_t exp);
      if (got !== exp) report_failure($sformatf("Fail %0t %s got %h expected %h",
                                                $time, name, got, exp));
   endtask

   task automatic check_result(input string name, input bench_result_t got,
                               input bench_result_t exp, input logic exact);
      logic bad;
      bad = (got.chan !== exp.chan) || (got.bytes !== exp.bytes);
      bad = bad || (exact ? (got.cycles !== exp.cycles) : (got.cycles < exp.cycles));
      if (bad) report_failure($sformatf("Fail %0t %s got %h expected %h",
                                        $time, name, got, exp));
   endtask

   // offset steps by stride and wraps once past mem_size
   function automatic logic [ADDR_W-1:0] next_offset(input logic [ADDR_W-1:0] off,
                                                     input bench_cfg_t c);
      logic [ADDR_W:0] sum;
      sum = {1'b0, off} + (ADDR_W + 1)'(c.stride);
      if (sum >= {1'b0, c.mem_size}) sum = sum - {1'b0, c.mem_size};
      return sum[ADDR_W-1:0];
   endfunction

   function automatic stream_word_t ref_word(input int acc, input int w, input int chunk);
      stream_word_t wd;
      int           rem;
      rem     = chunk - w * DATA_BYTES;
      wd.data = {32'(acc), 32'(w)};
      wd.last = (rem <= DATA_BYTES);
      wd.keep = wd.last ? 8'((1 << rem) - 1) : '1;
      return wd;
   endfunction

   function automatic bench_cfg_t make_cfg(input logic [ADDR_W-1:0] base,
                                           input logic [ADDR_W-1:0] size, input int num,
                                           input int chunk, input int stride, input logic wr);
      bench_cfg_t c;
      c.base_addr    = base;
      c.mem_size     = size;
      c.num_accesses = LEN_W'(num);
      c.chunk_len    = LEN_W'(chunk);
      c.stride       = LEN_W'(stride);
      c.is_write     = wr;
      return c;
   endfunction

   // expected commands, write words and result for one run
   task automatic load_run(input int ch, input bench_cfg_t c);
      logic [ADDR_W-1:0] off;
      mem_cmd_t          mc;
      int                nwords;
      off    = '0;
      nwords = (int'(c.chunk_len) + DATA_BYTES - 1) / DATA_BYTES;
      for (int i = 0; i < int'(c.num_accesses); i++) begin
         mc.addr   = c.base_addr + off;
         mc.length = c.chunk_len;
         if (c.is_write) begin
            exp_wr_cmd[ch].push_back(mc);
            for (int w = 0; w < nwords; w++) exp_word[ch].push_back(ref_word(i, w, c.chunk_len));
         end else begin
            exp_rd_cmd[ch].push_back(mc);
         end
         off = next_offset(off, c);
      end
      exp_res[ch].chan   = chan_t'(ch);
      exp_res[ch].cycles = CYCLES_W'(c.num_accesses);
      exp_res[ch].bytes  = BYTES_W'(c.num_accesses) * BYTES_W'(c.chunk_len);
      exp_pending[ch]    = 1'b1;
   endtask

   task automatic present_cmd(input int ch, input bench_cfg_t c);
      @(negedge user_clk);
      cmd_valid = 1'b1;
      cmd.chan  = chan_t'(ch);
      cmd.cfg   = c;
   endtask

   task automatic wait_cmd_taken();
      int n;
      n = 0;
      while (1) begin
         @(posedge user_clk);
         if (cmd_ready) break;
         n++;
         if (n >= TIMEOUT) report_failure("command was never accepted");
      end
      @(negedge user_clk);
      cmd_valid = 1'b0;
   endtask

   task automatic wait_reset_done();
      int n;
      n = 0;
      while (user_aresetn !== 1'b1) begin
         @(posedge user_clk);
         n++;
         if (n >= TIMEOUT) report_failure("reset was never released");
      end
   endtask

   task automatic wait_result_valid();
      int n;
      n = 0;
      while (1) begin
         @(negedge user_clk);
         if (result_valid) break;
         n++;
         if (n >= TIMEOUT) report_failure("no result appeared");
      end
   endtask

   task automatic wait_runs_done();
      int n;
      n = 0;
      while (exp_pending != '0) begin
         @(negedge user_clk);
         n++;
         if (n >= TIMEOUT) report_failure("a run never returned its result");
      end
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
         if (exp_rd_cmd[ch].size() + exp_wr_cmd[ch].size() + exp_word[ch].size() != 0)
            report_failure($sformatf("expected memory traffic missing on channel %0d", ch));
      end
   endtask

   always @(negedge user_clk) begin
      case (ready_mode)
         0:       result_ready = 1'b0;
         1:       result_ready = 1'b1;
         default: result_ready = take_bit();
      endcase
   end

   // monitor and compare, sampled before the flops update
   always @(posedge user_clk) begin
      if (user_aresetn) begin
         for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (mem_rd_cmd_valid[ch] && mem_rd_cmd_ready[ch]) begin
               if (exp_rd_cmd[ch].size() == 0)
                  report_failure($sformatf("unexpected read command on channel %0d", ch));
               else
                  check_mem_cmd($sformatf("mem_rd_cmd[%0d]", ch), mem_rd_cmd[ch],
                                exp_rd_cmd[ch].pop_front());
            end
            if (mem_wr_cmd_valid[ch] && mem_wr_cmd_ready[ch]) begin
               if (exp_wr_cmd[ch].size() == 0)
                  report_failure($sformatf("unexpected write command on channel %0d", ch));
               else
                  check_mem_cmd($sformatf("mem_wr_cmd[%0d]", ch), mem_wr_cmd[ch],
                                exp_wr_cmd[ch].pop_front());
            end
            if (mem_wr_data_valid[ch] && mem_wr_data_ready[ch]) begin
               if (exp_word[ch].size() == 0)
                  report_failure($sformatf("unexpected write data on channel %0d", ch));
               else
                  check_word($sformatf("mem_wr_data[%0d]", ch), mem_wr_data[ch],
                             exp_word[ch].pop_front());
            end
            // read data only shows up during a read run, which drains it
            if (mem_rd_data_valid[ch])
               check_bit($sformatf("mem_rd_data_ready[%0d]", ch), mem_rd_data_ready[ch], 1'b1);
         end
         if (stalled) begin
            if (!result_valid) report_failure("result_valid dropped before the result was taken");
            else check_result("result (stalled)", result, held_result, 1'b1);
         end
         if (result_valid && result_ready) begin
            if (!exp_pending[result.chan]) begin
               report_failure("result returned for a channel with no open run");
            end else begin
               check_result("result", result, exp_res[result.chan], 1'b0);
               exp_pending[result.chan] = 1'b0;
            end
         end
         stalled     = result_valid && !result_ready;
         held_result = result;
      end
   end

   initial begin
      bench_cfg_t c0;
      bench_cfg_t c1;
      cmd_valid    = 1'b0;
      cmd          = '0;
      result_ready = 1'b0;
      ready_mode   = 1;
      exp_pending  = '0;
      rng_state    = 16'd46938;
      stalled      = 1'b0;
      held_result  = '0;
      wait_reset_done();

      @(negedge user_clk);
      check_bit("cmd_ready", cmd_ready, 1'b1);
      check_bit("result_valid", result_valid, 1'b0);
      check_bit("memory valids", |{mem_rd_cmd_valid, mem_wr_cmd_valid, mem_wr_data_valid}, 1'b0);

      c0 = make_cfg(48'h1000, 48'd4096, 6, 64, 1536, 1'b0);    // read, wraps
      load_run(0, c0);
      present_cmd(0, c0);
      wait_cmd_taken();
      wait_runs_done();

      c1 = make_cfg(48'h2000_0000, 48'd2048, 4, 20, 700, 1'b1);  // partial last word
      load_run(1, c1);
      present_cmd(1, c1);
      wait_cmd_taken();
      wait_runs_done();

      ready_mode = 2;                                  // both channels, stalled results
      c0 = make_cfg(48'h4000, 48'd1024, 5, 13, 256, 1'b1);
      c1 = make_cfg(48'h8_0000, 48'd8192, 7, 40, 3000, 1'b0);
      load_run(0, c0);
      load_run(1, c1);
      present_cmd(0, c0);
      wait_cmd_taken();
      present_cmd(1, c1);
      wait_cmd_taken();
      wait_runs_done();

      ready_mode = 0;                                  // second command to a busy channel
      c1 = make_cfg(48'h10_0000, 48'd4096, 3, 16, 512, 1'b1);
      load_run(1, c1);
      present_cmd(1, c1);
      wait_cmd_taken();
      c0 = make_cfg(48'h20_0000, 48'd4096, 2, 8, 64, 1'b0);
      present_cmd(1, c0);
      wait_result_valid();
      repeat (8) begin
         @(posedge user_clk);
         check_bit("cmd_ready", cmd_ready, 1'b0);
      end
      ready_mode = 1;
      wait_runs_done();                                // earlier result taken first
      load_run(1, c0);
      wait_cmd_taken();
      wait_runs_done();

      c0 = make_cfg(48'h3000, 48'd4096, 0, 32, 64, 1'b0);      // zero accesses
      load_run(0, c0);
      present_cmd(0, c0);
      wait_cmd_taken();
      wait_runs_done();

      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
   output logic user_clk,
   output logic user_aresetn
);

   initial begin
      user_clk = 1'b0;
      forever #20 user_clk = ~user_clk;                // 40 ns period
   end

   initial begin
      user_aresetn = 1'b0;
      repeat (5) @(posedge user_clk);
      @(negedge user_clk);
      user_aresetn = 1'b1;                             // released on a falling edge
   end

endmodule

// File: dv/tb_mem_responder.sv
`timescale 1ns/1ns

module tb_mem_responder import bench_pkg::*; #(
   parameter logic [15:0] SEED = 16'd46938
) (
   input  logic         user_clk,
   input  logic         user_aresetn,
   input  logic         rd_cmd_valid,
   output logic         rd_cmd_ready,
   input  mem_cmd_t     rd_cmd,
   output logic         wr_cmd_ready,
   output logic         wr_data_ready,
   output logic         rd_data_valid,
   input  logic         rd_data_ready,
   output stream_word_t rd_data
);

   logic [15:0] lfsr;
   int          len_q[$];                              // lengths of open read commands
   int          sent;                                  // bytes returned for len_q[0]
   logic        rd_taken;

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // ready high about three cycles in four
   function automatic logic rand_ready();
      logic a;
      lfsr = lfsr_step(lfsr);
      a = lfsr[0];
      lfsr = lfsr_step(lfsr);
      return a | lfsr[0];
   endfunction

   initial begin
      lfsr          = SEED;
      rd_cmd_ready  = 1'b0;
      wr_cmd_ready  = 1'b0;
      wr_data_ready = 1'b0;
      rd_data_valid = 1'b0;
      rd_data       = '0;
      sent          = 0;
      rd_taken      = 1'b0;
   end

   always @(posedge user_clk) begin
      if (!user_aresetn) begin
         len_q.delete();
         sent     = 0;
         rd_taken = 1'b0;
      end else begin
         rd_taken = rd_data_valid && rd_data_ready;
         if (rd_cmd_valid && rd_cmd_ready) begin
            len_q.push_back(int'(rd_cmd.length));
         end
         if (rd_taken) begin
            if (rd_data.last) begin
               void'(len_q.pop_front());
               sent = 0;
            end else begin
               sent += DATA_BYTES;
            end
         end
      end
   end

   always @(negedge user_clk) begin
      int rem;
      if (!user_aresetn) begin
         rd_cmd_ready  = 1'b0;
         wr_cmd_ready  = 1'b0;
         wr_data_ready = 1'b0;
         rd_data_valid = 1'b0;
      end else begin
         rd_cmd_ready  = rand_ready();
         wr_cmd_ready  = rand_ready();
         wr_data_ready = rand_ready();
         if (!(rd_data_valid && !rd_taken)) begin    // a stalled word stays put
            rd_data_valid = 1'b0;
            if (len_q.size() != 0 && rand_ready()) begin
               rem = len_q[0] - sent;
               for (int b = 0; b < DATA_W; b++) begin
                  lfsr = lfsr_step(lfsr);
                  rd_data.data[b] = lfsr[0];
               end
               rd_data.last  = (rem <= DATA_BYTES);
               rd_data.keep  = rd_data.last ? 8'((1 << rem) - 1) : '1;
               rd_data_valid = 1'b1;
            end
         end
      end
   end

endmodule

// File: verilog/access_generator.sv
`timescale 1ns/1ns

module access_generator import bench_pkg::*; (
   input  logic                user_clk,
   input  logic                user_aresetn,
   input  logic                start,
   input  bench_cfg_t          cfg,
   output logic                mem_rd_cmd_valid,
   input  logic                mem_rd_cmd_ready,
   output mem_cmd_t            mem_rd_cmd,
   output logic                mem_wr_cmd_valid,
   input  logic                mem_wr_cmd_ready,
   output mem_cmd_t            mem_wr_cmd,
   output logic                mem_wr_data_valid,
   input  logic                mem_wr_data_ready,
   output stream_word_t        mem_wr_data,
   input  logic                mem_rd_data_valid,
   output logic                mem_rd_data_ready,
   input  stream_word_t        mem_rd_data,
   output logic                done,
   output logic [CYCLES_W-1:0] cycles
);

   logic                running;
   logic [LEN_W-1:0]    cmd_cnt;        // accesses issued
   logic [LEN_W-1:0]    acc_cnt;        // accesses finished on the data side
   logic [LEN_W-1:0]    word_cnt;       // word index inside the write access
   logic [ADDR_W-1:0]   offset;
   logic [ADDR_W:0]     offset_sum;
   logic [ADDR_W:0]     offset_wrap;
   logic [ADDR_W-1:0]   offset_next;
   logic [CYCLES_W-1:0] cyc_cnt;
   logic [LEN_W-1:0]    rem_bytes;      // bytes left in the write access
   logic                last_word;
   logic                cmd_pending;
   logic                data_pending;
   logic                cmd_fire;
   logic                wr_fire;
   logic                rd_fire;
   mem_cmd_t            cur_cmd;
   stream_word_t        wr_word;

   assign cmd_pending  = running & (cmd_cnt != cfg.num_accesses);
   assign data_pending = running & (acc_cnt != cfg.num_accesses);

   // offset walk; a single subtraction brings it back inside mem_size
   assign offset_sum  = {1'b0, offset} + {{(ADDR_W + 1 - LEN_W){1'b0}}, cfg.stride};
   assign offset_wrap = offset_sum - {1'b0, cfg.mem_size};
   assign offset_next = (offset_sum >= {1'b0, cfg.mem_size}) ? offset_wrap[ADDR_W-1:0]
                                                             : offset_sum[ADDR_W-1:0];

   assign cur_cmd.addr   = cfg.base_addr + offset;
   assign cur_cmd.length = cfg.chunk_len;

   assign mem_rd_cmd_valid = cmd_pending & ~cfg.is_write;
   assign mem_wr_cmd_valid = cmd_pending & cfg.is_write;
   assign mem_rd_cmd       = cur_cmd;
   assign mem_wr_cmd       = cur_cmd;

   assign cmd_fire = (mem_rd_cmd_valid & mem_rd_cmd_ready) |
                     (mem_wr_cmd_valid & mem_wr_cmd_ready);

   // write words, tagged with access and word index
   assign rem_bytes = cfg.chunk_len - (word_cnt << WORD_SHIFT);
   assign last_word = (rem_bytes <= LEN_W'(DATA_BYTES));

   assign wr_word.data = {acc_cnt, word_cnt};
   assign wr_word.keep = last_word ? ~({DATA_BYTES{1'b1}} << rem_bytes[KEEP_CNT_W-1:0])
                                   : {DATA_BYTES{1'b1}};
   assign wr_word.last = last_word;

   assign mem_wr_data_valid = data_pending & cfg.is_write;
   assign mem_wr_data       = wr_word;
   assign wr_fire           = mem_wr_data_valid & mem_wr_data_ready;

   // reads are always drained while running
   assign mem_rd_data_ready = running & ~cfg.is_write;
   assign rd_fire           = mem_rd_data_valid & mem_rd_data_ready & mem_rd_data.last &
                              data_pending;

   // all commands out and all data moved
   assign done   = running & (cmd_cnt == cfg.num_accesses) & (acc_cnt == cfg.num_accesses);
   assign cycles = cyc_cnt + CYCLES_W'(1);             // include the done cycle

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         running  <= 1'b0;
         cmd_cnt  <= '0;
         acc_cnt  <= '0;
         word_cnt <= '0;
         offset   <= '0;
         cyc_cnt  <= '0;
      end else if (start) begin
         running  <= 1'b1;
         cmd_cnt  <= '0;
         acc_cnt  <= '0;
         word_cnt <= '0;
         offset   <= '0;
         cyc_cnt  <= CYCLES_W'(1);                     // start cycle counts
      end else if (running) begin
         if (done) begin
            running <= 1'b0;                           // cycles frozen from here
         end else begin
            cyc_cnt <= cyc_cnt + CYCLES_W'(1);
         end
         if (cmd_fire) begin
            cmd_cnt <= cmd_cnt + LEN_W'(1);
            offset  <= offset_next;
         end
         if (wr_fire) begin
            if (last_word) begin
               word_cnt <= '0;
               acc_cnt  <= acc_cnt + LEN_W'(1);
            end else begin
               word_cnt <= word_cnt + LEN_W'(1);
            end
         end
         if (rd_fire) begin
            acc_cnt <= acc_cnt + LEN_W'(1);            // one per returned chunk
         end
      end
   end

endmodule

// File: verilog/bench_controller.sv
`timescale 1ns/1ns

module bench_controller import bench_pkg::*; (
   input  logic                                  user_clk,
   input  logic                                  user_aresetn,
   input  logic                                  cmd_valid,
   output logic                                  cmd_ready,
   input  bench_cmd_t                            cmd,
   output logic                                  result_valid,
   input  logic                                  result_ready,
   output bench_result_t                         result,
   output logic [NUM_CHANNELS-1:0]               start,
   output bench_cfg_t [NUM_CHANNELS-1:0]         cfg,
   input  logic [NUM_CHANNELS-1:0]               done,
   input  logic [NUM_CHANNELS-1:0][CYCLES_W-1:0] cycles,
   input  logic [NUM_CHANNELS-1:0][BYTES_W-1:0]  bytes
);

   logic [NUM_CHANNELS-1:0]          busy;       // running or result not yet returned
   logic [NUM_CHANNELS-1:0]          pend;       // result captured, waiting for the stream
   bench_result_t [NUM_CHANNELS-1:0] res_q;
   logic                             hold;       // stalled result keeps its channel
   chan_t                            hold_chan;
   chan_t                            sel;
   logic                             cmd_fire;
   logic                             res_fire;

   assign cmd_ready = ~busy[cmd.chan];
   assign cmd_fire  = cmd_valid & cmd_ready;

   // lowest pending channel wins, unless a stalled result is on the bus
   always_comb begin
      sel = hold_chan;
      if (!hold) begin
         sel = '0;
         for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
            if (pend[i]) begin
               sel = chan_t'(i);
            end
         end
      end
   end

   assign result_valid = |pend;
   assign result       = res_q[sel];
   assign res_fire     = result_valid & result_ready;

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         busy      <= '0;
         pend      <= '0;
         start     <= '0;
         hold      <= 1'b0;
         hold_chan <= '0;
      end else begin
         start <= '0;                                   // one-cycle pulse
         if (cmd_fire) begin
            busy[cmd.chan]  <= 1'b1;
            start[cmd.chan] <= 1'b1;
         end
         for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (done[i]) begin
               pend[i] <= 1'b1;
            end
         end
         if (res_fire) begin
            pend[sel] <= 1'b0;
            busy[sel] <= 1'b0;                          // channel idle again
         end
         hold      <= result_valid & ~result_ready;
         hold_chan <= sel;
      end
   end

   // settings and result payload
   always_ff @(posedge user_clk) begin
      if (cmd_fire) begin
         cfg[cmd.chan] <= cmd.cfg;                      // held for the whole run
      end
      for (int i = 0; i < NUM_CHANNELS; i++) begin
         if (done[i]) begin
            res_q[i].chan   <= chan_t'(i);
            res_q[i].cycles <= cycles[i];
            res_q[i].bytes  <= bytes[i];
         end
      end
   end

endmodule

// File: verilog/bench_pkg.sv
package bench_pkg;

   localparam int NUM_CHANNELS = 2;                       // 0 host dma, 1 ddr
   localparam int CHAN_W       = $clog2(NUM_CHANNELS);
   localparam int DATA_BYTES   = 8;
   localparam int DATA_W       = DATA_BYTES * 8;
   localparam int WORD_SHIFT   = $clog2(DATA_BYTES);      // bytes to words
   localparam int KEEP_CNT_W   = $clog2(DATA_BYTES + 1);  // 0..DATA_BYTES
   localparam int ADDR_W       = 48;
   localparam int LEN_W        = 32;
   localparam int CYCLES_W     = 64;
   localparam int BYTES_W      = 48;

   typedef logic [CHAN_W-1:0] chan_t;

   // run settings, base address in the low bits
   typedef struct packed {
      logic              is_write;
      logic [LEN_W-1:0]  stride;
      logic [LEN_W-1:0]  chunk_len;      // bytes per access
      logic [LEN_W-1:0]  num_accesses;
      logic [ADDR_W-1:0] mem_size;       // offset wraps at this size
      logic [ADDR_W-1:0] base_addr;
   } bench_cfg_t;

   typedef struct packed {
      chan_t      chan;
      bench_cfg_t cfg;
   } bench_cmd_t;

   typedef struct packed {
      logic [LEN_W-1:0]  length;         // bytes
      logic [ADDR_W-1:0] addr;
   } mem_cmd_t;

   typedef struct packed {
      logic [DATA_W-1:0]     data;
      logic [DATA_BYTES-1:0] keep;
      logic                  last;       // final word of an access
   } stream_word_t;

   typedef struct packed {
      chan_t               chan;
      logic [CYCLES_W-1:0] cycles;       // start to done, inclusive
      logic [BYTES_W-1:0]  bytes;
   } bench_result_t;

endpackage

// File: verilog/bench_role.sv
`timescale 1ns/1ns

module bench_role import bench_pkg::*; (
   input  logic                          user_clk,
   input  logic                          user_aresetn,
   input  logic                          cmd_valid,
   output logic                          cmd_ready,
   input  bench_cmd_t                    cmd,
   output logic                          result_valid,
   input  logic                          result_ready,
   output bench_result_t                 result,
   output logic [NUM_CHANNELS-1:0]       mem_rd_cmd_valid,
   input  logic [NUM_CHANNELS-1:0]       mem_rd_cmd_ready,
   output mem_cmd_t [NUM_CHANNELS-1:0]   mem_rd_cmd,
   output logic [NUM_CHANNELS-1:0]       mem_wr_cmd_valid,
   input  logic [NUM_CHANNELS-1:0]       mem_wr_cmd_ready,
   output mem_cmd_t [NUM_CHANNELS-1:0]   mem_wr_cmd,
   output logic [NUM_CHANNELS-1:0]       mem_wr_data_valid,
   input  logic [NUM_CHANNELS-1:0]       mem_wr_data_ready,
   output stream_word_t [NUM_CHANNELS-1:0] mem_wr_data,
   input  logic [NUM_CHANNELS-1:0]       mem_rd_data_valid,
   output logic [NUM_CHANNELS-1:0]       mem_rd_data_ready,
   input  stream_word_t [NUM_CHANNELS-1:0] mem_rd_data
);

   logic [NUM_CHANNELS-1:0]               start;
   bench_cfg_t [NUM_CHANNELS-1:0]         cfg;
   logic [NUM_CHANNELS-1:0]               done;
   logic [NUM_CHANNELS-1:0][CYCLES_W-1:0] cycles;
   logic [NUM_CHANNELS-1:0][BYTES_W-1:0]  bytes;

   bench_controller u_ctrl (
      .user_clk     (user_clk),
      .user_aresetn (user_aresetn),
      .cmd_valid    (cmd_valid),
      .cmd_ready    (cmd_ready),
      .cmd          (cmd),
      .result_valid (result_valid),
      .result_ready (result_ready),
      .result       (result),
      .start        (start),
      .cfg          (cfg),
      .done         (done),
      .cycles       (cycles),
      .bytes        (bytes)
   );

   // channel 0 host dma, channel 1 ddr, same datapath
   for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
      access_generator u_gen (
         .user_clk          (user_clk),
         .user_aresetn      (user_aresetn),
         .start             (start[ch]),
         .cfg               (cfg[ch]),
         .mem_rd_cmd_valid  (mem_rd_cmd_valid[ch]),
         .mem_rd_cmd_ready  (mem_rd_cmd_ready[ch]),
         .mem_rd_cmd        (mem_rd_cmd[ch]),
         .mem_wr_cmd_valid  (mem_wr_cmd_valid[ch]),
         .mem_wr_cmd_ready  (mem_wr_cmd_ready[ch]),
         .mem_wr_cmd        (mem_wr_cmd[ch]),
         .mem_wr_data_valid (mem_wr_data_valid[ch]),
         .mem_wr_data_ready (mem_wr_data_ready[ch]),
         .mem_wr_data       (mem_wr_data[ch]),
         .mem_rd_data_valid (mem_rd_data_valid[ch]),
         .mem_rd_data_ready (mem_rd_data_ready[ch]),
         .mem_rd_data       (mem_rd_data[ch]),
         .done              (done[ch]),
         .cycles            (cycles[ch])
      );

      stream_byte_counter u_cnt (
         .user_clk     (user_clk),
         .user_aresetn (user_aresetn),
         .start        (start[ch]),
         .rd_valid     (mem_rd_data_valid[ch]),
         .rd_ready     (mem_rd_data_ready[ch]),
         .rd_word      (mem_rd_data[ch]),
         .wr_valid     (mem_wr_data_valid[ch]),
         .wr_ready     (mem_wr_data_ready[ch]),
         .wr_word      (mem_wr_data[ch]),
         .bytes        (bytes[ch])
      );
   end

endmodule

// File: verilog/stream_byte_counter.sv
`timescale 1ns/1ns

module stream_byte_counter import bench_pkg::*; (
   input  logic               user_clk,
   input  logic               user_aresetn,
   input  logic               start,
   input  logic               rd_valid,
   input  logic               rd_ready,
   input  stream_word_t       rd_word,
   input  logic               wr_valid,
   input  logic               wr_ready,
   input  stream_word_t       wr_word,
   output logic [BYTES_W-1:0] bytes
);

   // contiguous set keep bits from bit 0
   function automatic logic [KEEP_CNT_W-1:0] keep_bytes(input logic [DATA_BYTES-1:0] keep);
      logic [KEEP_CNT_W-1:0] n;
      logic                  gap;
      n   = '0;
      gap = 1'b0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         if (!keep[i]) begin
            gap = 1'b1;
         end else if (!gap) begin
            n = n + KEEP_CNT_W'(1);
         end
      end
      return n;
   endfunction

   logic [KEEP_CNT_W-1:0] rd_add;
   logic [KEEP_CNT_W-1:0] wr_add;

   assign rd_add = (rd_valid & rd_ready) ? keep_bytes(rd_word.keep) : '0;
   assign wr_add = (wr_valid & wr_ready) ? keep_bytes(wr_word.keep) : '0;

   always_ff @(posedge user_clk) begin
      if (!user_aresetn || start) begin
         bytes <= '0;                                  // new run
      end else begin
         bytes <= bytes + BYTES_W'(rd_add) + BYTES_W'(wr_add);
      end
   end

endmodule
